// File: compile.f
common/mips_pkg.sv
common/id_ex_if.sv
logic/regfile.sv
logic/alu.sv
fetch/fetch.sv
decode/decode.sv
execute/execute.sv
logic/mem_wb.sv
core/core.sv
tests/core_chk.sv
tests/core_tb.sv

// File: Makefile
# Verilator build and run for the pipelined core testbench

VERILATOR ?= verilator
TOP ?= core_tb
BUILD_DIR ?= obj_dir
FILELIST ?= compile.f
VFLAGS ?= --binary --timing --assert -j 0

SIM := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf $(BUILD_DIR)

// File: tests/core_tb.sv
module core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_ROWS = 21;
    localparam int ROM_AW = 6;
    localparam int RAM_AW = 6;
    // First fetch one cycle after reset and write-back four cycles later
    localparam int FIRST_WB_CYCLE = 5;
    // Word accesses only on all four byte lanes
    localparam logic [3:0] RAM_SEL = 4'hf;

    // LU_WR writes one cycle late behind a load and SKIP sits behind a taken branch
    typedef enum logic [1:0] {WR, NO_WR, LU_WR, SKIP} row_kind_e;

    typedef struct packed {
        logic [31:0] inst;
        row_kind_e kind;
        logic [4:0] rd;
        logic [31:0] val;
    } row_t;

    logic clk;
    logic rst_i;
    logic [31:0] rom_data, rom_addr, ram_read_data, ram_addr, ram_write_data;
    logic rom_ce, ram_write_en, ram_ce;
    logic [31:0] debug_wb_pc, debug_wb_rf_wdata;
    logic [3:0] debug_wb_rf_wen;
    logic [4:0] debug_wb_rf_wnum;

    logic [31:0] rom [2**ROM_AW];
    logic [31:0] ram [2**RAM_AW];
    row_t rows [NUM_ROWS];
    int cycle;
    int store_count;
    int err_count = 0;
    int timeout_count = 0;
    logic [31:0] last_store_addr, last_store_data;

    core UUT (
        .clk(clk),
        .rst_i(rst_i),
        .rom_data_i(rom_data),
        .rom_addr_o(rom_addr),
        .rom_ce_o(rom_ce),
        .ram_read_data_i(ram_read_data),
        .ram_addr_o(ram_addr),
        .ram_write_data_o(ram_write_data),
        .ram_write_en_o(ram_write_en),
        .ram_ce_o(ram_ce),
        .debug_wb_pc_o(debug_wb_pc),
        .debug_wb_rf_wen_o(debug_wb_rf_wen),
        .debug_wb_rf_wnum_o(debug_wb_rf_wnum),
        .debug_wb_rf_wdata_o(debug_wb_rf_wdata)
    );

    bind core core_chk core_chk0 (
        .clk(clk),
        .rst_i(rst_i),
        .ram_write_en_i(ram_write_en_o),
        .ram_ce_i(ram_ce_o),
        .debug_wb_rf_wen_i(debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_i(debug_wb_rf_wnum_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Both memories answer in the same cycle
    assign rom_data = rom_ce ? rom[rom_addr[ROM_AW+1:2]] : 32'h0;
    assign ram_read_data = ram[ram_addr[RAM_AW+1:2]];

    always @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 2**RAM_AW; i++) begin
                ram[i] <= 32'ha500_0000 + i;
            end
            store_count <= 0;
        end else if (ram_ce && ram_write_en) begin
            for (int b = 0; b < 4; b++) begin
                if (RAM_SEL[b]) begin
                    ram[ram_addr[RAM_AW+1:2]][8*b +: 8] <= ram_write_data[8*b +: 8];
                end
            end
            store_count <= store_count + 1;
            last_store_addr <= ram_addr;
            last_store_data <= ram_write_data;
        end
    end

    always @(posedge clk) begin
        if (rst_i) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    function automatic logic [31:0] enc_r(input mips_pkg::funct_e fn, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt);
        return {mips_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(input mips_pkg::opcode_e op, input logic [4:0] rt,
                                          input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Program in ROM order, PC of row i is 4*i
    task automatic build_program();
        // Immediates with zero-extend, sign-extend and upper half
        rows[0]  = '{enc_i(mips_pkg::OP_ORI, 5'd1, 5'd0, 16'h8001), WR, 5'd1, 32'h0000_8001};
        rows[1]  = '{enc_i(mips_pkg::OP_ADDIU, 5'd2, 5'd0, 16'hfffe), WR, 5'd2, 32'hffff_fffe};
        rows[2]  = '{enc_i(mips_pkg::OP_LUI, 5'd3, 5'd0, 16'h1234), WR, 5'd3, 32'h1234_0000};
        // Dependent chain through both forwarding paths
        rows[3]  = '{enc_r(mips_pkg::FN_ADDU, 5'd4, 5'd1, 5'd2), WR, 5'd4, 32'h0000_7fff};
        rows[4]  = '{enc_r(mips_pkg::FN_SUBU, 5'd5, 5'd4, 5'd3), WR, 5'd5, 32'hedcc_7fff};
        rows[5]  = '{enc_r(mips_pkg::FN_AND, 5'd6, 5'd5, 5'd1), WR, 5'd6, 32'h0000_0001};
        rows[6]  = '{enc_r(mips_pkg::FN_OR, 5'd7, 5'd6, 5'd3), WR, 5'd7, 32'h1234_0001};
        rows[7]  = '{enc_r(mips_pkg::FN_XOR, 5'd8, 5'd7, 5'd5), WR, 5'd8, 32'hfff8_7ffe};
        rows[8]  = '{enc_r(mips_pkg::FN_SLT, 5'd9, 5'd8, 5'd6), WR, 5'd9, 32'h0000_0001};
        rows[9]  = '{enc_r(mips_pkg::FN_SLT, 5'd10, 5'd6, 5'd8), WR, 5'd10, 32'h0000_0000};
        // Store, load back and use the load at once
        rows[10] = '{enc_i(mips_pkg::OP_SW, 5'd7, 5'd0, 16'h0010), NO_WR, 5'd0, 32'h0};
        rows[11] = '{enc_i(mips_pkg::OP_LW, 5'd11, 5'd0, 16'h0010), WR, 5'd11, 32'h1234_0001};
        rows[12] = '{enc_r(mips_pkg::FN_ADDU, 5'd12, 5'd11, 5'd1), LU_WR, 5'd12, 32'h1234_8002};
        // Taken BEQ to row 16 runs its delay slot and never row 15
        rows[13] = '{enc_i(mips_pkg::OP_BEQ, 5'd12, 5'd12, 16'h0002), NO_WR, 5'd0, 32'h0};
        rows[14] = '{enc_i(mips_pkg::OP_ORI, 5'd13, 5'd0, 16'h00aa), WR, 5'd13, 32'h0000_00aa};
        rows[15] = '{enc_i(mips_pkg::OP_ORI, 5'd14, 5'd0, 16'h00bb), SKIP, 5'd14, 32'h0000_00bb};
        rows[16] = '{enc_i(mips_pkg::OP_BNE, 5'd13, 5'd13, 16'h0005), NO_WR, 5'd0, 32'h0};
        rows[17] = '{enc_i(mips_pkg::OP_ORI, 5'd15, 5'd0, 16'h0cc0), WR, 5'd15, 32'h0000_0cc0};
        rows[18] = '{enc_r(mips_pkg::FN_ADDU, 5'd16, 5'd13, 5'd15), WR, 5'd16, 32'h0000_0d6a};
        // Write to r0 is dropped
        rows[19] = '{enc_r(mips_pkg::FN_ADDU, 5'd0, 5'd1, 5'd2), NO_WR, 5'd0, 32'h0};
        rows[20] = '{enc_r(mips_pkg::FN_ADDU, 5'd17, 5'd0, 5'd16), WR, 5'd17, 32'h0000_0d6a};
    endtask

    task automatic report_and_finish();
        $display("Errors: %0d mismatches, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    initial begin
        #((NUM_ROWS + 20) * CLK_PERIOD);
        $display("Timeout: the program did not finish within the expected run time");
        timeout_count++;
        report_and_finish();
    end

    initial begin
        int slot;
        rst_i = 1'b1;
        // Unused opcode everywhere else runs as a no-op
        for (int i = 0; i < 2**ROM_AW; i++) begin
            rom[i] = {6'h3f, 26'(i)};
        end
        build_program();
        for (int i = 0; i < NUM_ROWS; i++) begin
            rom[i] = rows[i].inst;
        end
        repeat (3) @(posedge clk);
        #1 rst_i = 1'b0;

        @(negedge clk);
        if ({rom_ce, ram_ce, ram_write_en, debug_wb_rf_wen} !== 7'h0) begin
            $display("FAIL %0d ns: rom_ce_o/ram_ce_o/ram_write_en_o/debug_wb_rf_wen_o %s %h got %h",
                     $time, "expected", 7'h0, {rom_ce, ram_ce, ram_write_en, debug_wb_rf_wen});
            err_count++;
        end

        slot = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].kind == SKIP) begin
                continue;
            end
            if (rows[i].kind == LU_WR) begin
                slot++;
            end
            if (rows[i].kind != NO_WR) begin
                do begin
                    @(negedge clk);
                end while (debug_wb_rf_wen == 4'h0);
                if (debug_wb_pc !== 32'(i * 4)) begin
                    $display("FAIL %0d ns: debug_wb_pc_o expected %h got %h",
                             $time, 32'(i * 4), debug_wb_pc);
                    err_count++;
                end
                if (debug_wb_rf_wen !== 4'hf) begin
                    $display("FAIL %0d ns: debug_wb_rf_wen_o expected %h got %h",
                             $time, 4'hf, debug_wb_rf_wen);
                    err_count++;
                end
                if (debug_wb_rf_wnum !== rows[i].rd) begin
                    $display("FAIL %0d ns: debug_wb_rf_wnum_o expected %0d got %0d",
                             $time, rows[i].rd, debug_wb_rf_wnum);
                    err_count++;
                end
                if (debug_wb_rf_wdata !== rows[i].val) begin
                    $display("FAIL %0d ns: debug_wb_rf_wdata_o expected %h got %h",
                             $time, rows[i].val, debug_wb_rf_wdata);
                    err_count++;
                end
                if (cycle != FIRST_WB_CYCLE + slot) begin
                    $display("FAIL %0d ns: debug_wb_rf_wen_o cycle expected %0d got %0d",
                             $time, FIRST_WB_CYCLE + slot, cycle);
                    err_count++;
                end
            end
            slot++;
        end

        // Nothing past the program may write
        repeat (4) begin
            @(negedge clk);
            if (debug_wb_rf_wen != 4'h0) begin
                $display("Unexpected register write to r%0d at %0d ns after the program ended",
                         debug_wb_rf_wnum, $time);
                err_count++;
            end
        end

        if (store_count != 1) begin
            $display("Expected one store to data memory, saw %0d", store_count);
            err_count++;
        end
        if (last_store_addr !== 32'h0000_0010) begin
            $display("FAIL %0d ns: ram_addr_o expected %h got %h",
                     $time, 32'h0000_0010, last_store_addr);
            err_count++;
        end
        if (last_store_data !== 32'h1234_0001) begin
            $display("FAIL %0d ns: ram_write_data_o expected %h got %h",
                     $time, 32'h1234_0001, last_store_data);
            err_count++;
        end
        report_and_finish();
    end

endmodule

// File: tests/core_chk.sv
module core_chk (
    input logic clk,
    input logic rst_i,
    input logic ram_write_en_i,
    input logic ram_ce_i,
    input logic [3:0] debug_wb_rf_wen_i,
    input logic [mips_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // Stores only go out with the chip enable set
    write_has_ce: assert property (@(posedge clk) disable iff (rst_i)
        ram_write_en_i |-> ram_ce_i)
        else $error("ram_write_en_o high while ram_ce_o low");

    // No write-back during reset or in the first cycle out of it
    wb_quiet_in_reset: assert property (@(posedge clk)
        (rst_i || $past(rst_i)) |=> debug_wb_rf_wen_i == 4'h0)
        else $error("debug_wb_rf_wen_o active around reset");

    no_wb_to_r0: assert property (@(posedge clk) disable iff (rst_i)
        debug_wb_rf_wen_i != 4'h0 |-> debug_wb_rf_wnum_i != '0)
        else $error("register 0 written on the debug port");

endmodule

// File: core/core.sv
module core (
    input  logic clk,
    input  logic rst_i,

    input  logic [mips_pkg::DATA_W-1:0] rom_data_i,
    output logic [mips_pkg::DATA_W-1:0] rom_addr_o,
    output logic rom_ce_o,

    input  logic [mips_pkg::DATA_W-1:0] ram_read_data_i,
    output logic [mips_pkg::DATA_W-1:0] ram_addr_o,
    output logic [mips_pkg::DATA_W-1:0] ram_write_data_o,
    output logic ram_write_en_o,
    output logic ram_ce_o,

    output logic [mips_pkg::DATA_W-1:0] debug_wb_pc_o,
    output logic [3:0] debug_wb_rf_wen_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum_o,
    output logic [mips_pkg::DATA_W-1:0] debug_wb_rf_wdata_o
);

    // Fetch to decode
    logic [mips_pkg::DATA_W-1:0] if_pc, if_inst;

    // Decode back to fetch
    logic stall, branch_taken;
    logic [mips_pkg::DATA_W-1:0] branch_target;

    // Forwarding paths into decode
    logic ex_fwd_en, ex_is_load, mem_fwd_en;
    logic [mips_pkg::REG_ADDR_W-1:0] ex_fwd_addr, mem_fwd_addr;
    logic [mips_pkg::DATA_W-1:0] ex_fwd_data, mem_fwd_data;

    // Execute to memory
    logic [mips_pkg::DATA_W-1:0] mem_result, mem_addr, mem_store_data, mem_pc;
    mips_pkg::mem_op_e mem_op;
    logic mem_wr_en;
    logic [mips_pkg::REG_ADDR_W-1:0] mem_wr_addr;

    // Write-back
    logic wb_en;

    id_ex_if id_ex ();

    assign debug_wb_rf_wen_o = {4{wb_en}};

    fetch fetch0 (
        .clk(clk),
        .rst_i(rst_i),
        .stall_i(stall),
        .branch_taken_i(branch_taken),
        .branch_target_i(branch_target),
        .rom_data_i(rom_data_i),
        .rom_addr_o(rom_addr_o),
        .rom_ce_o(rom_ce_o),
        .if_pc_o(if_pc),
        .if_inst_o(if_inst)
    );

    decode decode0 (
        .clk(clk),
        .rst_i(rst_i),
        .if_pc_i(if_pc),
        .if_inst_i(if_inst),
        .ex_fwd_en_i(ex_fwd_en),
        .ex_fwd_addr_i(ex_fwd_addr),
        .ex_fwd_data_i(ex_fwd_data),
        .ex_is_load_i(ex_is_load),
        .mem_fwd_en_i(mem_fwd_en),
        .mem_fwd_addr_i(mem_fwd_addr),
        .mem_fwd_data_i(mem_fwd_data),
        .wb_en_i(wb_en),
        .wb_addr_i(debug_wb_rf_wnum_o),
        .wb_data_i(debug_wb_rf_wdata_o),
        .stall_o(stall),
        .branch_taken_o(branch_taken),
        .branch_target_o(branch_target),
        .id_ex(id_ex)
    );

    execute execute0 (
        .clk(clk),
        .rst_i(rst_i),
        .id_ex(id_ex),
        .ex_fwd_en_o(ex_fwd_en),
        .ex_fwd_addr_o(ex_fwd_addr),
        .ex_fwd_data_o(ex_fwd_data),
        .ex_is_load_o(ex_is_load),
        .mem_result_o(mem_result),
        .mem_addr_o(mem_addr),
        .mem_store_data_o(mem_store_data),
        .mem_op_o(mem_op),
        .mem_wr_en_o(mem_wr_en),
        .mem_wr_addr_o(mem_wr_addr),
        .mem_pc_o(mem_pc)
    );

    mem_wb mem_wb0 (
        .clk(clk),
        .rst_i(rst_i),
        .mem_result_i(mem_result),
        .mem_addr_i(mem_addr),
        .mem_store_data_i(mem_store_data),
        .mem_op_i(mem_op),
        .mem_wr_en_i(mem_wr_en),
        .mem_wr_addr_i(mem_wr_addr),
        .mem_pc_i(mem_pc),
        .ram_read_data_i(ram_read_data_i),
        .ram_addr_o(ram_addr_o),
        .ram_write_data_o(ram_write_data_o),
        .ram_write_en_o(ram_write_en_o),
        .ram_ce_o(ram_ce_o),
        .mem_fwd_en_o(mem_fwd_en),
        .mem_fwd_addr_o(mem_fwd_addr),
        .mem_fwd_data_o(mem_fwd_data),
        .wb_en_o(wb_en),
        .wb_addr_o(debug_wb_rf_wnum_o),
        .wb_data_o(debug_wb_rf_wdata_o),
        .wb_pc_o(debug_wb_pc_o)
    );

endmodule

// File: logic/mem_wb.sv
module mem_wb (
    input  logic clk,
    input  logic rst_i,
    input  logic [mips_pkg::DATA_W-1:0] mem_result_i,
    input  logic [mips_pkg::DATA_W-1:0] mem_addr_i,
    input  logic [mips_pkg::DATA_W-1:0] mem_store_data_i,
    input  mips_pkg::mem_op_e mem_op_i,
    input  logic mem_wr_en_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] mem_wr_addr_i,
    input  logic [mips_pkg::DATA_W-1:0] mem_pc_i,
    input  logic [mips_pkg::DATA_W-1:0] ram_read_data_i,
    output logic [mips_pkg::DATA_W-1:0] ram_addr_o,
    output logic [mips_pkg::DATA_W-1:0] ram_write_data_o,
    output logic ram_write_en_o,
    output logic ram_ce_o,
    output logic mem_fwd_en_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] mem_fwd_addr_o,
    output logic [mips_pkg::DATA_W-1:0] mem_fwd_data_o,
    output logic wb_en_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] wb_addr_o,
    output logic [mips_pkg::DATA_W-1:0] wb_data_o,
    output logic [mips_pkg::DATA_W-1:0] wb_pc_o
);

    logic [mips_pkg::DATA_W-1:0] stage_result;

    // Data memory port
    assign ram_addr_o = mem_addr_i;
    assign ram_write_data_o = mem_store_data_i;
    assign ram_write_en_o = (mem_op_i == mips_pkg::MEM_STORE);
    assign ram_ce_o = (mem_op_i != mips_pkg::MEM_NONE);

    assign stage_result = (mem_op_i == mips_pkg::MEM_LOAD) ? ram_read_data_i : mem_result_i;

    assign mem_fwd_en_o = mem_wr_en_i;
    assign mem_fwd_addr_o = mem_wr_addr_i;
    assign mem_fwd_data_o = stage_result;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_en_o <= 1'b0;
        end else begin
            wb_en_o <= mem_wr_en_i;
        end
        wb_addr_o <= mem_wr_addr_i;
        wb_data_o <= stage_result;
        wb_pc_o <= mem_pc_i;
    end

endmodule

// File: execute/execute.sv
module execute (
    input  logic clk,
    input  logic rst_i,
    id_ex_if.exe id_ex,
    output logic ex_fwd_en_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] ex_fwd_addr_o,
    output logic [mips_pkg::DATA_W-1:0] ex_fwd_data_o,
    output logic ex_is_load_o,
    output logic [mips_pkg::DATA_W-1:0] mem_result_o,
    output logic [mips_pkg::DATA_W-1:0] mem_addr_o,
    output logic [mips_pkg::DATA_W-1:0] mem_store_data_o,
    output mips_pkg::mem_op_e mem_op_o,
    output logic mem_wr_en_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] mem_wr_addr_o,
    output logic [mips_pkg::DATA_W-1:0] mem_pc_o
);

    logic [mips_pkg::DATA_W-1:0] result;

    alu alu0 (
        .op_i(id_ex.alu_op),
        .a_i(id_ex.operand_1),
        .b_i(id_ex.operand_2),
        .result_o(result)
    );

    // Forwarding to decode from this cycle's result
    assign ex_fwd_en_o = id_ex.reg_write_en;
    assign ex_fwd_addr_o = id_ex.reg_write_addr;
    assign ex_fwd_data_o = result;
    assign ex_is_load_o = (id_ex.mem_op == mips_pkg::MEM_LOAD);

    // Execute/memory register
    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem_op_o <= mips_pkg::MEM_NONE;
            mem_wr_en_o <= 1'b0;
        end else begin
            mem_op_o <= id_ex.mem_op;
            mem_wr_en_o <= id_ex.reg_write_en;
        end
        mem_result_o <= result;
        // Word accesses only
        mem_addr_o <= {result[mips_pkg::DATA_W-1:2], 2'b00};
        mem_store_data_o <= id_ex.store_data;
        mem_wr_addr_o <= id_ex.reg_write_addr;
        mem_pc_o <= id_ex.pc;
    end

endmodule

// File: decode/decode.sv
module decode (
    input  logic clk,
    input  logic rst_i,
    input  logic [mips_pkg::DATA_W-1:0] if_pc_i,
    input  logic [mips_pkg::DATA_W-1:0] if_inst_i,
    input  logic ex_fwd_en_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] ex_fwd_addr_i,
    input  logic [mips_pkg::DATA_W-1:0] ex_fwd_data_i,
    input  logic ex_is_load_i,
    input  logic mem_fwd_en_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] mem_fwd_addr_i,
    input  logic [mips_pkg::DATA_W-1:0] mem_fwd_data_i,
    input  logic wb_en_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] wb_addr_i,
    input  logic [mips_pkg::DATA_W-1:0] wb_data_i,
    output logic stall_o,
    output logic branch_taken_o,
    output logic [mips_pkg::DATA_W-1:0] branch_target_o,
    id_ex_if.dec id_ex
);

    mips_pkg::opcode_e opcode;
    mips_pkg::funct_e funct;
    mips_pkg::alu_op_e alu_op;
    mips_pkg::mem_op_e mem_op;
    logic [mips_pkg::REG_ADDR_W-1:0] rs, rt, dest;
    logic [mips_pkg::DATA_W-1:0] imm_val, rf_data_1, rf_data_2, src_1, src_2;
    logic wr_en, use_imm, use_rs, use_rt, is_beq, is_bne;

    assign opcode = mips_pkg::opcode_e'(if_inst_i[31:26]);
    assign funct = mips_pkg::funct_e'(if_inst_i[5:0]);
    assign rs = if_inst_i[25:21];
    assign rt = if_inst_i[20:16];

    regfile regfile0 (
        .clk(clk),
        .rst_i(rst_i),
        .wr_en_i(wb_en_i),
        .wr_addr_i(wb_addr_i),
        .wr_data_i(wb_data_i),
        .rd_addr_1_i(rs),
        .rd_addr_2_i(rt),
        .rd_data_1_o(rf_data_1),
        .rd_data_2_o(rf_data_2)
    );

    // Field decode with unknown words falling through as no-ops
    always_comb begin
        alu_op = mips_pkg::ALU_ADD;
        mem_op = mips_pkg::MEM_NONE;
        dest = rt;
        imm_val = {{16{if_inst_i[15]}}, if_inst_i[15:0]};
        wr_en = 1'b0;
        use_imm = 1'b1;
        use_rs = 1'b1;
        use_rt = 1'b0;
        is_beq = 1'b0;
        is_bne = 1'b0;
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                dest = if_inst_i[15:11];
                use_imm = 1'b0;
                use_rt = 1'b1;
                wr_en = 1'b1;
                case (funct)
                    mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
                    default:           wr_en = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: wr_en = 1'b1;
            mips_pkg::OP_ORI: begin
                alu_op = mips_pkg::ALU_OR;
                imm_val = {16'h0000, if_inst_i[15:0]};
                wr_en = 1'b1;
            end
            mips_pkg::OP_LUI: begin
                alu_op = mips_pkg::ALU_LUI;
                imm_val = {16'h0000, if_inst_i[15:0]};
                wr_en = 1'b1;
                use_rs = 1'b0;
            end
            mips_pkg::OP_LW: begin
                mem_op = mips_pkg::MEM_LOAD;
                wr_en = 1'b1;
            end
            mips_pkg::OP_SW: begin
                mem_op = mips_pkg::MEM_STORE;
                use_rt = 1'b1;
            end
            mips_pkg::OP_BEQ: begin
                is_beq = 1'b1;
                use_rt = 1'b1;
            end
            mips_pkg::OP_BNE: begin
                is_bne = 1'b1;
                use_rt = 1'b1;
            end
            default: use_rs = 1'b0;
        endcase
    end

    // Execute result first, then memory result, then register file
    function automatic logic [mips_pkg::DATA_W-1:0] forward(
        input logic [mips_pkg::REG_ADDR_W-1:0] addr,
        input logic [mips_pkg::DATA_W-1:0] rf_data
    );
        if (ex_fwd_en_i && ex_fwd_addr_i == addr) begin
            return ex_fwd_data_i;
        end else if (mem_fwd_en_i && mem_fwd_addr_i == addr) begin
            return mem_fwd_data_i;
        end
        return rf_data;
    endfunction

    always_comb begin
        src_1 = forward(rs, rf_data_1);
        src_2 = forward(rt, rf_data_2);
    end

    // Load result not ready until memory stage
    assign stall_o = ex_is_load_i && ex_fwd_en_i &&
                     ((use_rs && ex_fwd_addr_i == rs) || (use_rt && ex_fwd_addr_i == rt));

    assign branch_taken_o = !stall_o &&
                            ((is_beq && src_1 == src_2) || (is_bne && src_1 != src_2));
    assign branch_target_o = if_pc_i + 32'd4 + {{14{if_inst_i[15]}}, if_inst_i[15:0], 2'b00};

    // Decode/execute register where a stall turns the slot into a bubble
    always_ff @(posedge clk) begin
        if (rst_i || stall_o) begin
            id_ex.reg_write_en <= 1'b0;
            id_ex.mem_op <= mips_pkg::MEM_NONE;
        end else begin
            id_ex.reg_write_en <= wr_en && dest != '0;
            id_ex.mem_op <= mem_op;
        end
        id_ex.alu_op <= alu_op;
        id_ex.operand_1 <= src_1;
        id_ex.operand_2 <= use_imm ? imm_val : src_2;
        id_ex.store_data <= src_2;
        id_ex.reg_write_addr <= dest;
        id_ex.pc <= if_pc_i;
    end

endmodule

// File: fetch/fetch.sv
module fetch (
    input  logic clk,
    input  logic rst_i,
    input  logic stall_i,
    input  logic branch_taken_i,
    input  logic [mips_pkg::DATA_W-1:0] branch_target_i,
    input  logic [mips_pkg::DATA_W-1:0] rom_data_i,
    output logic [mips_pkg::DATA_W-1:0] rom_addr_o,
    output logic rom_ce_o,
    output logic [mips_pkg::DATA_W-1:0] if_pc_o,
    output logic [mips_pkg::DATA_W-1:0] if_inst_o
);

    logic [mips_pkg::DATA_W-1:0] pc;

    assign rom_addr_o = pc;

    // Program counter
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc <= mips_pkg::RESET_PC;
            rom_ce_o <= 1'b0;
        end else begin
            rom_ce_o <= 1'b1;
            if (rom_ce_o && !stall_i) begin
                pc <= branch_taken_i ? branch_target_i : pc + 32'd4;
            end
        end
    end

    // Fetch/decode register with an all-zero word acting as a NOP
    always_ff @(posedge clk) begin
        if (rst_i || !rom_ce_o) begin
            if_inst_o <= '0;
        end else if (!stall_i) begin
            if_inst_o <= rom_data_i;
        end
        if (!stall_i) begin
            if_pc_o <= pc;
        end
    end

endmodule

// File: logic/alu.sv
module alu (
    input  mips_pkg::alu_op_e op_i,
    input  logic [mips_pkg::DATA_W-1:0] a_i,
    input  logic [mips_pkg::DATA_W-1:0] b_i,
    output logic [mips_pkg::DATA_W-1:0] result_o
);

    always_comb begin
        case (op_i)
            mips_pkg::ALU_ADD: begin
                result_o = a_i + b_i;
            end
            mips_pkg::ALU_SUB: begin
                result_o = a_i - b_i;
            end
            mips_pkg::ALU_AND: begin
                result_o = a_i & b_i;
            end
            mips_pkg::ALU_OR: begin
                result_o = a_i | b_i;
            end
            mips_pkg::ALU_XOR: begin
                result_o = a_i ^ b_i;
            end
            // Signed compare
            mips_pkg::ALU_SLT: begin
                result_o = {{(mips_pkg::DATA_W-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            end
            mips_pkg::ALU_LUI: begin
                result_o = {b_i[15:0], 16'h0000};
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// File: logic/regfile.sv
module regfile (
    input  logic clk,
    input  logic rst_i,
    input  logic wr_en_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] wr_addr_i,
    input  logic [mips_pkg::DATA_W-1:0] wr_data_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rd_addr_1_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rd_addr_2_i,
    output logic [mips_pkg::DATA_W-1:0] rd_data_1_o,
    output logic [mips_pkg::DATA_W-1:0] rd_data_2_o
);

    logic [mips_pkg::DATA_W-1:0] regs [2**mips_pkg::REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (!rst_i && wr_en_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // Register 0 is hardwired and a same-cycle write passes straight through
    assign rd_data_1_o = (rd_addr_1_i == '0) ? '0 :
                         (wr_en_i && wr_addr_i == rd_addr_1_i) ? wr_data_i :
                         regs[rd_addr_1_i];
    assign rd_data_2_o = (rd_addr_2_i == '0) ? '0 :
                         (wr_en_i && wr_addr_i == rd_addr_2_i) ? wr_data_i :
                         regs[rd_addr_2_i];

endmodule

// File: common/id_ex_if.sv
interface id_ex_if;

    mips_pkg::alu_op_e alu_op;
    logic [mips_pkg::DATA_W-1:0] operand_1;
    logic [mips_pkg::DATA_W-1:0] operand_2;
    logic [mips_pkg::DATA_W-1:0] store_data;
    logic [mips_pkg::REG_ADDR_W-1:0] reg_write_addr;
    logic reg_write_en;
    mips_pkg::mem_op_e mem_op;
    // Address of the instruction, kept for the debug port
    logic [mips_pkg::DATA_W-1:0] pc;

    modport dec (
        output alu_op, operand_1, operand_2, store_data,
        output reg_write_addr, reg_write_en, mem_op, pc
    );

    modport exe (
        input alu_op, operand_1, operand_2, store_data,
        input reg_write_addr, reg_write_en, mem_op, pc
    );

endinterface

// File: common/mips_pkg.sv
package mips_pkg;

    localparam int DATA_W = 32;
    localparam int REG_ADDR_W = 5;

    // First fetch address after reset
    localparam logic [DATA_W-1:0] RESET_PC = 32'h0000_0000;

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // Function field of SPECIAL instructions, bits 5:0
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

endpackage
